// ==== src/syn_config.svh ====
`ifndef SYN_CONFIG_SVH
`define SYN_CONFIG_SVH

// data word and code word width.
`define SYN_WORD        16
// instruction pointer and code address width.
`define SYN_IPR_W       16
// external registers presented by the register file.
`define SYN_NUM_REGS    8

// move fields, dest in the top bits and src below.
`define SYN_DEST_W      6
`define SYN_SRC_W       10

// control destinations in the 0x30..0x3f block.
`define SYN_D_CLRF      6'h30
`define SYN_D_SETF      6'h31
`define SYN_D_BR        6'h38
`define SYN_D_BN        6'h39
`define SYN_D_RETADDR   6'h3e
`define SYN_D_RETURN    6'h3f

// source map.
`define SYN_S_RETADDR   10'h03e
// top two src bits of the small constant block 0x200..0x2ff.
`define SYN_S_SMALL_HI  2'h2
`define SYN_S_AD0       10'h300
`define SYN_S_AD1       10'h310
`define SYN_S_AND0      10'h330
`define SYN_S_OR0       10'h334
`define SYN_S_XOR0      10'h338
`define SYN_S_FLAGS     10'h340
`define SYN_S_SH1R      10'h350
`define SYN_S_SH1L      10'h351
`define SYN_S_SH4L      10'h352
`define SYN_S_SH4R      10'h353
`define SYN_S_NEG1      10'h360
`define SYN_S_IMM16     10'h3a0

`endif

// ==== src/syn_pkg.sv ====
`default_nettype none

`include "syn_config.svh"

package syn_pkg;

    // one word on the data bus or from code memory.
    typedef logic [`SYN_WORD-1:0] syn_word_t;

    // a move instruction, dest on top.
    typedef struct packed {
        logic [`SYN_DEST_W-1:0] dest;
        logic [`SYN_SRC_W-1:0]  src;
    } syn_move_t;

    // the exr word, decoded as a move or taken whole.
    // whole when it holds a branch target or an inline constant.
    typedef union packed {
        syn_move_t move;
        syn_word_t raw;
    } syn_instr_u;

    // decoded control strobes, all qualified by exec.
    typedef struct packed {
        logic clrf;
        logic setf;
        logic br;
        logic bn;
        logic ret;
        logic wr_retaddr;
        logic imm16;
    } syn_ctrl_t;

    // condition flags kept by the execution units.
    typedef struct packed {
        logic ad0_zero;
        logic ad0_carry;
        logic and0_zero;
        logic ad1_zero;
    } syn_flags_t;

    // flags word as seen on source 0x340 and by the branch select.
    // bit 0 was the ad2 zero flag, now tied low.
    function automatic syn_word_t syn_flags_word(input syn_flags_t f);
        return {(`SYN_WORD-5)'(1), f.ad0_zero, f.ad0_carry, f.and0_zero, f.ad1_zero, 1'b0};
    endfunction

endpackage

`default_nettype wire

// ==== src/syn_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "syn_config.svh"

module syn_fetch (
    input  wire                        sysreset,
    input  wire                        sysclk,
    input  wire syn_pkg::syn_word_t    code_in,
    input  wire                        code_ready,
    output logic [`SYN_IPR_W-1:0]      code_addr,
    input  wire syn_pkg::syn_word_t    bus,
    input  wire syn_pkg::syn_ctrl_t    ctrl,
    input  wire syn_pkg::syn_flags_t   flags,
    output syn_pkg::syn_instr_u        exr,
    output logic                       exec,
    output syn_pkg::syn_word_t         ret_addr
);
    import syn_pkg::*;

    // instruction pointer, always the address being fetched.
    logic [`SYN_IPR_W-1:0] ipr;
    logic [`SYN_IPR_W-1:0] ipr_inc;

    // exr holds a branch target on this cycle, not an opcode.
    logic branch_skip;
    // exr holds the inline constant of an imm16 move.
    logic imm_skip;

    syn_word_t flag_word;
    logic      sel_flag;
    logic      branch_accept;

    assign code_addr = ipr;
    assign ipr_inc   = ipr + `SYN_IPR_W'(1);

    // a word executes when it has arrived and is a real opcode.
    assign exec = code_ready && !(branch_skip || imm_skip);

    // low four src bits pick one flag of the flags word.
    assign flag_word = syn_flags_word(flags);
    assign sel_flag  = flag_word[exr.move.src[3:0]];

    // br takes on a set flag, bn on a clear one.
    always_comb begin
        if (ctrl.br) begin
            branch_accept = sel_flag;
        end else if (ctrl.bn) begin
            branch_accept = !sel_flag;
        end else begin
            branch_accept = 1'b0;
        end
    end

    always_ff @(posedge sysreset or posedge sysclk) begin
        if (sysclk) begin
            ipr         <= '0;
            exr         <= '0;
            ret_addr    <= '0;
            branch_skip <= 1'b0;
            imm_skip    <= 1'b0;
        end else begin
            // exr follows code memory, waiting while it is not ready.
            if (code_ready) begin
                exr.raw <= code_in;
            end

            // the word fetched behind a branch is its target.
            // it is on code_in in the cycle the branch executes.
            if (branch_accept) begin
                ipr <= code_in;
            end else if (ctrl.ret) begin
                // swap with the return address.
                ipr <= ret_addr;
            end else if (code_ready) begin
                ipr <= ipr_inc;
            end

            // return saves the address after the return word.
            if (ctrl.ret) begin
                ret_addr <= ipr;
            end else if (ctrl.wr_retaddr) begin
                ret_addr <= bus;
            end

            // every branch or return lands a target word in exr.
            // held while code memory stalls.
            branch_skip <= ctrl.br || ctrl.bn || ctrl.ret || (branch_skip && !code_ready);

            // the constant word after imm16 is data, never executed.
            imm_skip <= ctrl.imm16 || (imm_skip && !code_ready);
        end
    end

endmodule

`default_nettype wire

// ==== src/syn_exec_units.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "syn_config.svh"

module syn_exec_units (
    input  wire                                           sysreset,
    input  wire                                           sysclk,
    input  wire syn_pkg::syn_word_t [`SYN_NUM_REGS-1:0]   r,
    input  wire                                           ops_loaded,
    input  wire syn_pkg::syn_ctrl_t                       ctrl,
    input  wire syn_pkg::syn_word_t                       bus,
    output syn_pkg::syn_word_t                            ad0,
    output syn_pkg::syn_word_t                            ad1,
    output syn_pkg::syn_word_t                            and0,
    output syn_pkg::syn_word_t                            or0,
    output syn_pkg::syn_word_t                            xor0,
    output syn_pkg::syn_flags_t                           flags
);
    import syn_pkg::*;

    // r0 and r1 feed ad0 and the bitwise units, r2 and r3 feed ad1.
    syn_word_t r0;
    syn_word_t r1;
    syn_word_t r2;
    syn_word_t r3;

    logic [`SYN_WORD:0] ad0_sum;
    syn_word_t          ad1_sum;
    syn_word_t          and0_val;

    // ad0 captures one cycle after r0 or r1 was loaded.
    logic ad0_load;

    logic ad0_zero_flag;
    logic ad0_carry_flag;
    logic ad1_zero_flag;
    logic and0_zero_flag;

    assign r0 = r[0];
    assign r1 = r[1];
    assign r2 = r[2];
    assign r3 = r[3];

    // carry flag is the carry-in, which chains multi-word adds.
    assign ad0_sum  = {1'b0, r0} + {1'b0, r1} + {{`SYN_WORD{1'b0}}, ad0_carry_flag};
    assign ad1_sum  = r2 + r3;
    assign and0_val = r0 & r1;

    always_ff @(posedge sysreset or posedge sysclk) begin
        if (sysclk) begin
            ad0            <= '0;
            ad0_load       <= 1'b0;
            ad0_zero_flag  <= 1'b0;
            ad0_carry_flag <= 1'b0;
        end else begin
            ad0_load <= ops_loaded;
            if (ad0_load) begin
                ad0           <= ad0_sum[`SYN_WORD-1:0];
                ad0_zero_flag <= ~|ad0_sum[`SYN_WORD-1:0];
            end
            // setf and clrf use bus bit 0 as a mask on the carry.
            if (ctrl.setf) begin
                ad0_carry_flag <= ad0_carry_flag | bus[0];
            end else if (ctrl.clrf) begin
                ad0_carry_flag <= ad0_carry_flag & ~bus[0];
            end else if (ad0_load) begin
                ad0_carry_flag <= ad0_sum[`SYN_WORD];
            end
        end
    end

    // ad1 and the bitwise units run free every cycle.
    always_ff @(posedge sysreset or posedge sysclk) begin
        if (sysclk) begin
            ad1            <= '0;
            ad1_zero_flag  <= 1'b0;
            and0           <= '0;
            and0_zero_flag <= 1'b0;
            or0            <= '0;
            xor0           <= '0;
        end else begin
            ad1            <= ad1_sum;
            ad1_zero_flag  <= ~|ad1_sum;
            and0           <= and0_val;
            and0_zero_flag <= ~|and0_val;
            or0            <= r0 | r1;
            xor0           <= r0 ^ r1;
        end
    end

    assign flags = '{ad0_zero:  ad0_zero_flag,
                     ad0_carry: ad0_carry_flag,
                     and0_zero: and0_zero_flag,
                     ad1_zero:  ad1_zero_flag};

endmodule

`default_nettype wire

// ==== src/syn_data_bus.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "syn_config.svh"

module syn_data_bus (
    input  wire syn_pkg::syn_instr_u                      exr,
    input  wire                                           exec,
    input  wire syn_pkg::syn_word_t                       code_in,
    input  wire syn_pkg::syn_word_t [`SYN_NUM_REGS-1:0]   r,
    input  wire syn_pkg::syn_word_t                       ret_addr,
    input  wire syn_pkg::syn_word_t                       ad0,
    input  wire syn_pkg::syn_word_t                       ad1,
    input  wire syn_pkg::syn_word_t                       and0,
    input  wire syn_pkg::syn_word_t                       or0,
    input  wire syn_pkg::syn_word_t                       xor0,
    input  wire syn_pkg::syn_flags_t                      flags,
    output syn_pkg::syn_ctrl_t                            ctrl,
    output logic                                          ops_loaded,
    output logic [`SYN_NUM_REGS-1:0]                      r_read,
    output logic [`SYN_NUM_REGS-1:0]                      r_load,
    output syn_pkg::syn_word_t                            bus
);
    import syn_pkg::*;

    logic [`SYN_DEST_W-1:0] dest;
    logic [`SYN_SRC_W-1:0]  src;
    syn_word_t              r0;
    syn_word_t              small_const;
    // value of any non-register, non-constant source.
    syn_word_t              unit_val;

    assign dest = exr.move.dest;
    assign src  = exr.move.src;
    assign r0   = r[0];

    // low eight src bits, zero extended.
    assign small_const = {{(`SYN_WORD-8){1'b0}}, src[7:0]};

    // control destinations.
    always_comb begin
        ctrl.clrf       = exec && (dest == `SYN_D_CLRF);
        ctrl.setf       = exec && (dest == `SYN_D_SETF);
        ctrl.br         = exec && (dest == `SYN_D_BR);
        ctrl.bn         = exec && (dest == `SYN_D_BN);
        ctrl.ret        = exec && (dest == `SYN_D_RETURN);
        ctrl.wr_retaddr = exec && (dest == `SYN_D_RETADDR);
        // inline constant, the next code word rides the bus.
        ctrl.imm16      = exec && (src == `SYN_S_IMM16);
    end

    // one load strobe per destination register and one read strobe per source.
    always_comb begin
        for (int i = 0; i < `SYN_NUM_REGS; i++) begin
            r_load[i] = exec && (dest == `SYN_DEST_W'(i));
            r_read[i] = exec && (src == `SYN_SRC_W'(i));
        end
    end

    // operand change for ad0.
    assign ops_loaded = r_load[0] || r_load[1];

    always_comb begin
        case (src)
            `SYN_S_RETADDR: unit_val = ret_addr;
            `SYN_S_AD0:     unit_val = ad0;
            `SYN_S_AD1:     unit_val = ad1;
            `SYN_S_AND0:    unit_val = and0;
            `SYN_S_OR0:     unit_val = or0;
            `SYN_S_XOR0:    unit_val = xor0;
            `SYN_S_FLAGS:   unit_val = syn_flags_word(flags);
            // shifter, r0 only.
            `SYN_S_SH1R:    unit_val = {1'b0, r0[`SYN_WORD-1:1]};
            `SYN_S_SH1L:    unit_val = {r0[`SYN_WORD-2:0], 1'b0};
            `SYN_S_SH4L:    unit_val = {r0[`SYN_WORD-5:0], 4'h0};
            `SYN_S_SH4R:    unit_val = {4'h0, r0[`SYN_WORD-1:4]};
            `SYN_S_NEG1:    unit_val = '1;
            `SYN_S_IMM16:   unit_val = code_in;
            // unmapped sources read zero.
            default:        unit_val = '0;
        endcase
    end

    // registers, small constants and the units do not overlap in src space.
    always_comb begin
        bus = unit_val;
        if (src[`SYN_SRC_W-1:`SYN_SRC_W-2] == `SYN_S_SMALL_HI) begin
            bus = small_const;
        end
        for (int i = 0; i < `SYN_NUM_REGS; i++) begin
            if (src == `SYN_SRC_W'(i)) begin
                bus = r[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/syn_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "syn_config.svh"

module syn_core (
    input  wire                                           sysreset,
    input  wire                                           sysclk,
    output wire [`SYN_IPR_W-1:0]                          code_addr,
    input  wire syn_pkg::syn_word_t                       code_in,
    input  wire                                           code_ready,
    input  wire syn_pkg::syn_word_t [`SYN_NUM_REGS-1:0]   r,
    output wire [`SYN_NUM_REGS-1:0]                       r_read,
    output wire [`SYN_NUM_REGS-1:0]                       r_load,
    output wire syn_pkg::syn_word_t                       r_load_data
);
    import syn_pkg::*;

    syn_instr_u exr;
    logic       exec;
    syn_word_t  ret_addr;
    syn_ctrl_t  ctrl;
    syn_flags_t flags;
    logic       ops_loaded;
    syn_word_t  ad0;
    syn_word_t  ad1;
    syn_word_t  and0;
    syn_word_t  or0;
    syn_word_t  xor0;

    // fetch owns ipr, exr and the skip cycles.
    syn_fetch u_fetch (
        .sysreset   (sysreset),
        .sysclk     (sysclk),
        .code_in    (code_in),
        .code_ready (code_ready),
        .code_addr  (code_addr),
        .bus        (r_load_data),
        .ctrl       (ctrl),
        .flags      (flags),
        .exr        (exr),
        .exec       (exec),
        .ret_addr   (ret_addr)
    );

    // the data bus is also the register file write data.
    syn_data_bus u_data_bus (
        .exr        (exr),
        .exec       (exec),
        .code_in    (code_in),
        .r          (r),
        .ret_addr   (ret_addr),
        .ad0        (ad0),
        .ad1        (ad1),
        .and0       (and0),
        .or0        (or0),
        .xor0       (xor0),
        .flags      (flags),
        .ctrl       (ctrl),
        .ops_loaded (ops_loaded),
        .r_read     (r_read),
        .r_load     (r_load),
        .bus        (r_load_data)
    );

    syn_exec_units u_exec_units (
        .sysreset   (sysreset),
        .sysclk     (sysclk),
        .r          (r),
        .ops_loaded (ops_loaded),
        .ctrl       (ctrl),
        .bus        (r_load_data),
        .ad0        (ad0),
        .ad1        (ad1),
        .and0       (and0),
        .or0        (or0),
        .xor0       (xor0),
        .flags      (flags)
    );

endmodule

`default_nettype wire

// ==== tests/syn_core_props.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "syn_config.svh"

module syn_core_props (
    input wire                       sysreset,
    input wire                       sysclk,
    input wire                       exec,
    input wire [`SYN_NUM_REGS-1:0]   r_load
);

    // a move has one destination, so one load strobe at most.
    assert property (@(posedge sysreset) disable iff (sysclk) $onehot0(r_load))
        else $error("more than one r_load bit high");

    // loads only happen on executing cycles.
    assert property (@(posedge sysreset) disable iff (sysclk) !exec |-> (r_load == '0))
        else $error("r_load active while exec is low");

    // the core stays idle while reset is held.
    assert property (@(posedge sysreset) sysclk |-> !exec)
        else $error("exec high during reset");

endmodule

bind syn_core syn_core_props u_props (
    .sysreset  (sysreset),
    .sysclk    (sysclk),
    .exec      (exec),
    .r_load    (r_load)
);

`default_nettype wire

// ==== tests/syn_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "syn_config.svh"

module syn_core_tb;
    import syn_pkg::*;

    typedef logic [`SYN_NUM_REGS-1:0][`SYN_WORD-1:0] reg_bank_t;

    logic                        clk;
    logic                        rst;
    logic [`SYN_IPR_W-1:0]       code_addr;
    syn_word_t                   code_in;
    wire                         code_ready;
    reg_bank_t                   regs;
    logic [`SYN_NUM_REGS-1:0]    r_read;
    logic [`SYN_NUM_REGS-1:0]    r_load;
    syn_word_t                   r_load_data;

    // program memory, 256 words.
    syn_word_t prog [0:255];
    reg_bank_t expected;
    // read strobes seen per register, and the count the model predicts.
    reg_bank_t read_count;
    reg_bank_t expected_reads;
    logic      ready_q;
    integer    seed;
    logic      stall_en;
    logic      timed_out;
    int        errors;
    int        checks;
    int        tests_run;
    int        cur_test;
    logic      compare_ack;
    event      compare_ev;
    int        wp;

    // clock on sysreset and reset on sysclk, as the core names them.
    syn_core UUT (
        .sysreset    (clk),
        .sysclk      (rst),
        .code_addr   (code_addr),
        .code_in     (code_in),
        .code_ready  (code_ready),
        .r           (regs),
        .r_read      (r_read),
        .r_load      (r_load),
        .r_load_data (r_load_data)
    );

    always #5 clk = ~clk;

    // register file model, also counting read strobes.
    always @(posedge clk) begin
        if (rst) begin
            regs       <= '0;
            read_count <= '0;
        end else begin
            for (int i = 0; i < `SYN_NUM_REGS; i++) begin
                if (r_load[i]) begin
                    regs[i] <= r_load_data;
                end
                if (r_read[i]) begin
                    read_count[i] <= read_count[i] + 16'd1;
                end
            end
        end
    end

    // code memory is never ready while reset is held.
    assign code_ready = ready_q && !rst;

    // code memory answers on the falling edge, with optional stalls.
    always @(negedge clk) begin
        logic ready;
        ready = !stall_en || (($random(seed) & 3) != 0);
        ready_q <= ready;
        code_in <= ready ? prog[code_addr[7:0]] : 16'hdead;
    end

    function automatic syn_word_t mv(input logic [5:0] d, input logic [9:0] s);
        return {d, s};
    endfunction

    // small constant source.
    function automatic logic [9:0] sc(input logic [7:0] n);
        return {2'b10, n};
    endfunction

    task automatic put(input syn_word_t w);
        prog[wp] = w;
        wp++;
    endtask

    // bn on the flag bit that always reads 0 jumps to itself.
    task automatic put_halt(output int halt);
        halt = wp;
        put(mv(`SYN_D_BN, 10'h000));
        put(syn_word_t'(halt));
    endtask

    // instruction level model of the core.
    function automatic reg_bank_t reference(input int halt, output reg_bank_t reads);
        reg_bank_t   rf;
        syn_word_t   ad0v;
        syn_word_t   ret;
        syn_word_t   bus;
        syn_word_t   w;
        syn_word_t   fw;
        syn_word_t   a1;
        logic [16:0] sum;
        logic        c;
        logic        z0;
        logic        pend;
        logic [5:0]  d;
        logic [9:0]  s;
        int          pc;
        int          nxt;
        int          steps;
        rf    = '0;
        reads = '0;
        ad0v  = '0;
        ret   = '0;
        c     = 1'b0;
        z0    = 1'b0;
        // the cleared exr runs r0 <= r0 once after reset.
        pend     = 1'b1;
        reads[0] = 16'd1;
        pc    = 0;
        steps = 0;
        while (pc != halt && steps < 1000) begin
            steps++;
            // ad0 recomputes after each r0 or r1 load.
            if (pend) begin
                sum  = {1'b0, rf[0]} + {1'b0, rf[1]} + {16'h0, c};
                ad0v = sum[15:0];
                z0   = (sum[15:0] == 16'h0);
                c    = sum[16];
                pend = 1'b0;
            end
            w  = prog[pc & 255];
            d  = w[15:10];
            s  = w[9:0];
            a1 = rf[2] + rf[3];
            fw = {11'h001, z0, c, (rf[0] & rf[1]) == 16'h0, a1 == 16'h0, 1'b0};
            nxt = pc + 1;
            if (s < 10'd8) begin
                bus = rf[s[2:0]];
                reads[s[2:0]] = reads[s[2:0]] + 16'd1;
            end else if (s[9:8] == 2'b10) begin
                bus = {8'h00, s[7:0]};
            end else begin
                case (s)
                    10'h03e: bus = ret;
                    10'h300: bus = ad0v;
                    10'h310: bus = a1;
                    10'h330: bus = rf[0] & rf[1];
                    10'h334: bus = rf[0] | rf[1];
                    10'h338: bus = rf[0] ^ rf[1];
                    10'h340: bus = fw;
                    10'h350: bus = rf[0] >> 1;
                    10'h351: bus = rf[0] << 1;
                    10'h352: bus = rf[0] << 4;
                    10'h353: bus = rf[0] >> 4;
                    10'h360: bus = 16'hffff;
                    10'h3a0: begin
                        bus = prog[(pc + 1) & 255];
                        nxt = pc + 2;
                    end
                    default: bus = 16'h0;
                endcase
            end
            if (d < 6'd8) begin
                rf[d[2:0]] = bus;
                if (d < 6'd2) begin
                    pend = 1'b1;
                end
            end
            case (d)
                6'h30: c = c & ~bus[0];
                6'h31: c = c | bus[0];
                6'h38: nxt = fw[s[3:0]] ? int'(prog[(pc + 1) & 255]) : pc + 2;
                6'h39: nxt = !fw[s[3:0]] ? int'(prog[(pc + 1) & 255]) : pc + 2;
                6'h3e: ret = bus;
                6'h3f: begin
                    nxt = ret;
                    ret = syn_word_t'(pc + 1);
                end
                default: ;
            endcase
            pc = nxt;
        end
        return rf;
    endfunction

    // builds test program n and returns its halt address.
    task automatic load_program(input int n, output int halt);
        for (int a = 0; a < 256; a++) begin
            prog[a] = syn_word_t'(a) ^ 16'hc3a5;
        end
        wp = 0;
        case (n)
            1: begin
                put(mv(6'd2, sc(8'h05)));
                put(mv(6'd3, sc(8'hff)));
                put(mv(6'd4, `SYN_S_NEG1));
                put(mv(6'd5, sc(8'h00)));
                put(mv(6'd6, 10'd4));
                put(mv(6'd7, sc(8'h80)));
                put(mv(6'd0, sc(8'h2a)));
                put(mv(6'd1, 10'd0));
            end
            2: begin
                put(mv(6'd0, `SYN_S_IMM16));
                put(16'h1234);
                // a data word that decodes as r3 <= 3.
                put(mv(6'd7, `SYN_S_IMM16));
                put(mv(6'd3, sc(8'h03)));
                put(mv(6'd1, sc(8'h07)));
                // a data word that decodes as a taken branch.
                put(mv(6'd2, `SYN_S_IMM16));
                put(mv(`SYN_D_BN, 10'h000));
            end
            3: begin
                put(mv(6'd0, `SYN_S_IMM16));
                put(16'hffff);
                put(mv(6'd1, sc(8'h01)));
                put(mv(6'd5, sc(8'h00)));
                put(mv(`SYN_D_CLRF, sc(8'h01)));
                // low word, carry out into the flag.
                put(mv(6'd1, sc(8'h01)));
                put(mv(6'd5, sc(8'h00)));
                put(mv(6'd2, `SYN_S_AD0));
                // high word adds the carry back in.
                put(mv(6'd1, sc(8'h02)));
                put(mv(6'd6, sc(8'h00)));
                put(mv(6'd3, `SYN_S_AD0));
                put(mv(6'd5, sc(8'h00)));
                put(mv(6'd4, `SYN_S_FLAGS));
                put(mv(`SYN_D_CLRF, sc(8'h01)));
                put(mv(`SYN_D_SETF, sc(8'h00)));
                put(mv(`SYN_D_SETF, sc(8'h01)));
                put(mv(6'd0, `SYN_S_IMM16));
                put(16'h8421);
                put(mv(6'd1, 10'd5));
                put(mv(6'd4, `SYN_S_SH1R));
                put(mv(6'd5, `SYN_S_SH4L));
                put(mv(6'd6, `SYN_S_AD0));
                put(mv(6'd2, `SYN_S_SH1L));
                put(mv(6'd7, `SYN_S_SH4R));
                put(mv(6'd3, `SYN_S_AD1));
                put(mv(6'd5, `SYN_S_XOR0));
                put(mv(6'd7, `SYN_S_OR0));
                put(mv(6'd6, `SYN_S_AND0));
            end
            4: begin
                put(mv(6'd0, sc(8'h05)));
                put(mv(6'd1, sc(8'h0a)));
                put(mv(6'd2, sc(8'h00)));
                put(mv(`SYN_D_BR, 10'd2));
                put(16'd6);
                put(mv(6'd2, sc(8'h11)));
                put(mv(6'd3, sc(8'h22)));
                put(mv(`SYN_D_BN, 10'd2));
                put(16'd11);
                put(mv(6'd4, sc(8'h33)));
                put(mv(6'd5, sc(8'h77)));
                put(mv(`SYN_D_CLRF, sc(8'h01)));
                put(mv(`SYN_D_BN, 10'd3));
                put(16'd15);
                put(mv(6'd6, sc(8'h44)));
                put(mv(`SYN_D_SETF, sc(8'h01)));
                put(mv(`SYN_D_BR, 10'd3));
                put(16'd19);
                put(mv(6'd6, sc(8'h55)));
                put(mv(`SYN_D_BR, 10'd1));
                put(16'd25);
                put(mv(6'd7, sc(8'h66)));
                put(mv(`SYN_D_BR, 10'd4));
                put(16'd25);
                put(mv(6'd4, `SYN_S_FLAGS));
            end
            default: begin
                // call the routine at 8 through the return address.
                put(mv(`SYN_D_RETADDR, `SYN_S_IMM16));
                put(16'd8);
                put(mv(`SYN_D_RETURN, sc(8'h00)));
                put(mv(6'd2, sc(8'h12)));
                put(mv(6'd4, `SYN_S_RETADDR));
            end
        endcase
        put_halt(halt);
        if (n == 5) begin
            wp = 8;
            put(mv(6'd3, sc(8'h34)));
            put(mv(6'd5, `SYN_S_RETADDR));
            put(mv(`SYN_D_RETURN, sc(8'h00)));
            put(mv(6'd6, sc(8'h99)));
        end
    endtask

    task automatic check_value(input string name, input syn_word_t got,
                               input syn_word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // compares the register file with the reference at the end of a test.
    always begin
        int errs_before;
        @(compare_ev);
        errs_before = errors;
        for (int i = 0; i < `SYN_NUM_REGS; i++) begin
            check_value($sformatf("r[%0d]", i), regs[i], expected[i]);
            check_value($sformatf("r_read[%0d] count", i), read_count[i],
                        expected_reads[i]);
        end
        if (errors == errs_before) begin
            $display("test %0d stalls=%0d: ok", cur_test, stall_en);
        end else begin
            $display("test %0d stalls=%0d: %0d mismatches", cur_test, stall_en,
                     errors - errs_before);
        end
        compare_ack = 1'b1;
    end

    task automatic run_test(input int n, input logic stalls);
        int   halt;
        logic done;
        @(negedge clk);
        rst      = 1'b1;
        stall_en <= stalls;
        load_program(n, halt);
        repeat (16) @(negedge clk);
        rst = 1'b0;
        expected = reference(halt, expected_reads);
        // the halt loop is executing once fetch has passed it.
        done = 1'b0;
        for (int cyc = 0; cyc < 3000 && !done; cyc++) begin
            @(negedge clk);
            if (code_addr == `SYN_IPR_W'(halt + 1)) begin
                done = 1'b1;
            end
        end
        if (!done) begin
            $display("timeout: test %0d never reached its halt loop", n);
            timed_out = 1'b1;
        end else begin
            cur_test    = n;
            compare_ack = 1'b0;
            -> compare_ev;
            for (int k = 0; k < 100 && !compare_ack; k++) begin
                #1;
            end
            if (!compare_ack) begin
                $display("timeout: register compare for test %0d did not finish", n);
                timed_out = 1'b1;
            end else begin
                tests_run++;
            end
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        ready_q    = 1'b0;
        code_in    = '0;
        regs       = '0;
        read_count = '0;
        stall_en   = 1'b0;
        timed_out  = 1'b0;
        seed       = 32'h12c22ffd;
        errors     = 0;
        checks     = 0;
        tests_run  = 0;
        cur_test   = 0;
        for (int n = 1; n <= 5 && !timed_out; n++) begin
            run_test(n, 1'b0);
        end
        // same programs with random code memory stalls.
        for (int n = 1; n <= 5 && !timed_out; n++) begin
            run_test(n, 1'b1);
        end
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+src
src/syn_pkg.sv
src/syn_fetch.sv
src/syn_exec_units.sv
src/syn_data_bus.sv
src/syn_core.sv
tests/syn_core_props.sv
tests/syn_core_tb.sv

// ==== Bender.yml ====
package:
  name: syn_core

sources:
  - include_dirs:
      - src
    files:
      - src/syn_pkg.sv
      - src/syn_fetch.sv
      - src/syn_exec_units.sv
      - src/syn_data_bus.sv
      - src/syn_core.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/syn_core_props.sv
      - tests/syn_core_tb.sv
